// File: common/bus_pkg.sv
`default_nettype none

package bus_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [63:0] beat_t;
  typedef logic [3:0]  lstrb_t;  // byte lanes of one word
  typedef logic [7:0]  bstrb_t;  // byte lanes of one beat
  typedef logic [2:0]  axsize_t;

  localparam axsize_t SIZE_B = 3'd0;
  localparam axsize_t SIZE_H = 3'd1;
  localparam axsize_t SIZE_W = 3'd2;

  localparam logic [1:0] RESP_OKAY = 2'b00;

  typedef enum logic [1:0] {RD_IDLE, RD_ADDR, RD_DATA, RD_DONE} rd_state_t;
  typedef enum logic [1:0] {ST_IDLE, ST_SEND, ST_RESP, ST_DONE} st_state_t;

  // requester strobe to transfer size
  function automatic axsize_t strb_to_size(input lstrb_t strb);
    axsize_t size;
    case (strb)
      4'h1:    size = SIZE_B;
      4'h3:    size = SIZE_H;
      default: size = SIZE_W;
    endcase
    return size;
  endfunction

endpackage

`default_nettype wire

// File: common/rd_if.sv
`timescale 1ns/1ps
`default_nettype none

// single-word read, four-phase req/ack
interface rd_if;
  logic             req;
  logic             ack;
  bus_pkg::addr_t   addr;
  bus_pkg::axsize_t size;
  bus_pkg::word_t   rdata;  // valid while ack

  modport requester (
    output req, addr, size,
    input  ack, rdata
  );

  modport server (
    input  req, addr, size,
    output ack, rdata
  );

endinterface

`default_nettype wire

// File: hw/load_steer.sv
`timescale 1ns/1ps
`default_nettype none

module load_steer #(
  parameter bus_pkg::addr_t MTIME_BASE = 32'h0200_BFF8
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             ld_req_i,
  input  bus_pkg::addr_t   ld_addr_i,
  input  bus_pkg::lstrb_t  ld_strb_i,
  output logic             ld_ack_o,
  output bus_pkg::word_t   ld_rdata_o,
  rd_if.requester          mem_rd,
  rd_if.requester          tmr_rd
);

  logic is_tmr;
  logic busy_q;   // handshake in progress
  logic sel_q;    // side latched at req rise
  logic use_tmr;

  assign is_tmr  = (ld_addr_i == MTIME_BASE) || (ld_addr_i == MTIME_BASE + 32'd4);
  assign use_tmr = busy_q ? sel_q : is_tmr;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= 1'b0;
      sel_q  <= 1'b0;
    end else if (!busy_q && ld_req_i) begin
      busy_q <= 1'b1;
      sel_q  <= is_tmr;
    end else if (busy_q && !ld_req_i && !ld_ack_o) begin
      busy_q <= 1'b0;  // both phases back to low
    end
  end

  assign mem_rd.req  = ld_req_i & ~use_tmr;
  assign mem_rd.addr = ld_addr_i;
  assign mem_rd.size = bus_pkg::strb_to_size(ld_strb_i);

  assign tmr_rd.req  = ld_req_i & use_tmr;
  assign tmr_rd.addr = ld_addr_i;
  assign tmr_rd.size = bus_pkg::SIZE_W;

  assign ld_ack_o   = use_tmr ? tmr_rd.ack : mem_rd.ack;
  assign ld_rdata_o = use_tmr ? tmr_rd.rdata : mem_rd.rdata;

endmodule

`default_nettype wire

// File: hw/read_arb/read_arb.sv
`timescale 1ns/1ps
`default_nettype none

module read_arb (
  input  logic              clk,
  input  logic              rst,
  input  logic              ifu_req_i,
  input  bus_pkg::addr_t    ifu_addr_i,
  output logic              ifu_ack_o,
  output bus_pkg::word_t    ifu_rdata_o,
  rd_if.server              ld,
  output bus_pkg::addr_t    araddr_o,
  output bus_pkg::axsize_t  arsize_o,
  output logic              arvalid_o,
  input  logic              arready_i,
  input  bus_pkg::beat_t    rdata_i,
  input  logic [1:0]        rresp_i,
  input  logic              rvalid_i,
  input  logic              rlast_i,
  output logic              rready_o
);

  bus_pkg::rd_state_t state_q;
  logic               gnt_ifu_q;  // 1: fetch owns the bus
  bus_pkg::addr_t     addr_q;
  bus_pkg::axsize_t   size_q;
  bus_pkg::word_t     rdata_q;
  logic               owner_req;
  logic               beat_done;
  bus_pkg::word_t     rd_half;

  assign owner_req = gnt_ifu_q ? ifu_req_i : ld.req;
  assign beat_done = rvalid_i & rlast_i;  // single beat, rlast comes with it
  assign rd_half   = addr_q[2] ? rdata_i[63:32] : rdata_i[31:0];

  // control
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q   <= bus_pkg::RD_IDLE;
      gnt_ifu_q <= 1'b0;
    end else begin
      case (state_q)
        bus_pkg::RD_IDLE: begin
          if (ifu_req_i) begin  // fetch first
            gnt_ifu_q <= 1'b1;
            state_q   <= bus_pkg::RD_ADDR;
          end else if (ld.req) begin
            gnt_ifu_q <= 1'b0;
            state_q   <= bus_pkg::RD_ADDR;
          end
        end
        bus_pkg::RD_ADDR: begin
          if (arready_i) state_q <= bus_pkg::RD_DATA;
        end
        bus_pkg::RD_DATA: begin
          if (beat_done) state_q <= bus_pkg::RD_DONE;
        end
        bus_pkg::RD_DONE: begin
          if (!owner_req) state_q <= bus_pkg::RD_IDLE;
        end
        default: state_q <= bus_pkg::RD_IDLE;
      endcase
    end
  end

  // request and response payload
  always_ff @(posedge clk) begin
    if (state_q == bus_pkg::RD_IDLE) begin
      if (ifu_req_i) begin
        addr_q <= ifu_addr_i;
        size_q <= bus_pkg::SIZE_W;  // fetch is always a word
      end else if (ld.req) begin
        addr_q <= ld.addr;
        size_q <= ld.size;
      end
    end
    if (state_q == bus_pkg::RD_DATA && beat_done) begin
      rdata_q <= rd_half;
    end
  end

  assign araddr_o  = addr_q;
  assign arsize_o  = size_q;
  assign arvalid_o = (state_q == bus_pkg::RD_ADDR);
  assign rready_o  = 1'b1;

  assign ifu_ack_o   = (state_q == bus_pkg::RD_DONE) & gnt_ifu_q;
  assign ifu_rdata_o = rdata_q;
  assign ld.ack      = (state_q == bus_pkg::RD_DONE) & ~gnt_ifu_q;
  assign ld.rdata    = rdata_q;

endmodule

`default_nettype wire

// File: hw/clint/clint_timer.sv
`timescale 1ns/1ps
`default_nettype none

module clint_timer #(
  parameter bus_pkg::addr_t MTIME_BASE = 32'h0200_BFF8
) (
  input  logic clk,
  input  logic rst,
  rd_if.server rd
);

  logic [63:0]    mtime_q;
  bus_pkg::addr_t offset;
  logic           ack_q;
  bus_pkg::word_t rdata_q;

  assign offset = rd.addr - MTIME_BASE;  // 0 low word, 4 high word

  always_ff @(posedge clk) begin
    if (rst) begin
      mtime_q <= 64'd0;
    end else begin
      mtime_q <= mtime_q + 64'd1;
    end
  end

  // four-phase read, one cycle to ack
  always_ff @(posedge clk) begin
    if (rst) begin
      ack_q <= 1'b0;
    end else if (rd.req && !ack_q) begin
      ack_q <= 1'b1;
    end else if (!rd.req && ack_q) begin
      ack_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rd.req && !ack_q) begin
      rdata_q <= offset[2] ? mtime_q[63:32] : mtime_q[31:0];
    end
  end

  assign rd.ack   = ack_q;
  assign rd.rdata = rdata_q;

endmodule

`default_nettype wire

// File: hw/store_path/store_path.sv
`timescale 1ns/1ps
`default_nettype none

module store_path (
  input  logic              clk,
  input  logic              rst,
  input  logic              st_req_i,
  input  bus_pkg::addr_t    st_addr_i,
  input  bus_pkg::word_t    st_data_i,
  input  bus_pkg::lstrb_t   st_strb_i,
  output logic              st_ack_o,
  output bus_pkg::addr_t    awaddr_o,
  output bus_pkg::axsize_t  awsize_o,
  output logic              awvalid_o,
  input  logic              awready_i,
  output bus_pkg::beat_t    wdata_o,
  output bus_pkg::bstrb_t   wstrb_o,
  output logic              wlast_o,
  output logic              wvalid_o,
  input  logic              wready_i,
  input  logic [1:0]        bresp_i,
  input  logic              bvalid_i,
  output logic              bready_o
);

  bus_pkg::st_state_t state_q;
  logic               aw_sent_q;
  logic               w_sent_q;
  bus_pkg::addr_t     addr_q;
  bus_pkg::word_t     data_q;
  bus_pkg::lstrb_t    strb_q;
  logic               aw_fin;
  logic               w_fin;
  logic [1:0]         k;
  bus_pkg::word_t     data_sh;
  bus_pkg::lstrb_t    strb_sh;

  assign aw_fin = aw_sent_q | (awvalid_o & awready_i);
  assign w_fin  = w_sent_q | (wvalid_o & wready_i);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q   <= bus_pkg::ST_IDLE;
      aw_sent_q <= 1'b0;
      w_sent_q  <= 1'b0;
    end else begin
      case (state_q)
        bus_pkg::ST_IDLE: begin
          aw_sent_q <= 1'b0;
          w_sent_q  <= 1'b0;
          if (st_req_i) state_q <= bus_pkg::ST_SEND;
        end
        bus_pkg::ST_SEND: begin
          aw_sent_q <= aw_fin;
          w_sent_q  <= w_fin;
          if (aw_fin && w_fin) state_q <= bus_pkg::ST_RESP;
        end
        bus_pkg::ST_RESP: begin
          if (bvalid_i) state_q <= bus_pkg::ST_DONE;
        end
        bus_pkg::ST_DONE: begin
          if (!st_req_i) state_q <= bus_pkg::ST_IDLE;
        end
        default: state_q <= bus_pkg::ST_IDLE;
      endcase
    end
  end

  // store payload, captured at req
  always_ff @(posedge clk) begin
    if (state_q == bus_pkg::ST_IDLE && st_req_i) begin
      addr_q <= st_addr_i;
      data_q <= st_data_i;
      strb_q <= st_strb_i;
    end
  end

  // lane alignment
  assign k       = addr_q[1:0];
  assign data_sh = data_q << {k, 3'b000};
  assign strb_sh = strb_q << k;

  assign awaddr_o  = addr_q;
  assign awsize_o  = bus_pkg::strb_to_size(strb_q);  // unshifted strobe
  assign awvalid_o = (state_q == bus_pkg::ST_SEND) & ~aw_sent_q;

  assign wdata_o  = {data_sh, data_sh};
  assign wstrb_o  = addr_q[2] ? {strb_sh, 4'b0000} : {4'b0000, strb_sh};
  assign wvalid_o = (state_q == bus_pkg::ST_SEND) & ~w_sent_q;
  assign wlast_o  = wvalid_o;  // one beat

  assign bready_o = 1'b1;
  assign st_ack_o = (state_q == bus_pkg::ST_DONE);

endmodule

`default_nettype wire

// File: hw/bus_top.sv
`timescale 1ns/1ps
`default_nettype none

module bus_top #(
  parameter bus_pkg::addr_t MTIME_BASE = 32'h0200_BFF8
) (
  input  logic              clk,
  input  logic              rst,
  // fetch
  input  logic              ifu_req_i,
  input  bus_pkg::addr_t    ifu_addr_i,
  output logic              ifu_ack_o,
  output bus_pkg::word_t    ifu_rdata_o,
  // load
  input  logic              ld_req_i,
  input  bus_pkg::addr_t    ld_addr_i,
  input  bus_pkg::lstrb_t   ld_strb_i,
  output logic              ld_ack_o,
  output bus_pkg::word_t    ld_rdata_o,
  // store
  input  logic              st_req_i,
  input  bus_pkg::addr_t    st_addr_i,
  input  bus_pkg::word_t    st_data_i,
  input  bus_pkg::lstrb_t   st_strb_i,
  output logic              st_ack_o,
  // AXI AR / R
  output bus_pkg::addr_t    araddr_o,
  output bus_pkg::axsize_t  arsize_o,
  output logic              arvalid_o,
  input  logic              arready_i,
  input  bus_pkg::beat_t    rdata_i,
  input  logic [1:0]        rresp_i,
  input  logic              rvalid_i,
  input  logic              rlast_i,
  output logic              rready_o,
  // AXI AW / W / B
  output bus_pkg::addr_t    awaddr_o,
  output bus_pkg::axsize_t  awsize_o,
  output logic              awvalid_o,
  input  logic              awready_i,
  output bus_pkg::beat_t    wdata_o,
  output bus_pkg::bstrb_t   wstrb_o,
  output logic              wlast_o,
  output logic              wvalid_o,
  input  logic              wready_i,
  input  logic [1:0]        bresp_i,
  input  logic              bvalid_i,
  output logic              bready_o
);

  rd_if mem_rd ();
  rd_if tmr_rd ();

  load_steer #(.MTIME_BASE(MTIME_BASE)) i_load_steer (
    .clk        (clk),
    .rst        (rst),
    .ld_req_i   (ld_req_i),
    .ld_addr_i  (ld_addr_i),
    .ld_strb_i  (ld_strb_i),
    .ld_ack_o   (ld_ack_o),
    .ld_rdata_o (ld_rdata_o),
    .mem_rd     (mem_rd.requester),
    .tmr_rd     (tmr_rd.requester)
  );

  read_arb i_read_arb (
    .clk         (clk),
    .rst         (rst),
    .ifu_req_i   (ifu_req_i),
    .ifu_addr_i  (ifu_addr_i),
    .ifu_ack_o   (ifu_ack_o),
    .ifu_rdata_o (ifu_rdata_o),
    .ld          (mem_rd.server),
    .araddr_o    (araddr_o),
    .arsize_o    (arsize_o),
    .arvalid_o   (arvalid_o),
    .arready_i   (arready_i),
    .rdata_i     (rdata_i),
    .rresp_i     (rresp_i),
    .rvalid_i    (rvalid_i),
    .rlast_i     (rlast_i),
    .rready_o    (rready_o)
  );

  clint_timer #(.MTIME_BASE(MTIME_BASE)) i_clint_timer (
    .clk (clk),
    .rst (rst),
    .rd  (tmr_rd.server)
  );

  store_path i_store_path (
    .clk       (clk),
    .rst       (rst),
    .st_req_i  (st_req_i),
    .st_addr_i (st_addr_i),
    .st_data_i (st_data_i),
    .st_strb_i (st_strb_i),
    .st_ack_o  (st_ack_o),
    .awaddr_o  (awaddr_o),
    .awsize_o  (awsize_o),
    .awvalid_o (awvalid_o),
    .awready_i (awready_i),
    .wdata_o   (wdata_o),
    .wstrb_o   (wstrb_o),
    .wlast_o   (wlast_o),
    .wvalid_o  (wvalid_o),
    .wready_i  (wready_i),
    .bresp_i   (bresp_i),
    .bvalid_i  (bvalid_i),
    .bready_o  (bready_o)
  );

endmodule

`default_nettype wire

// File: dv/axi_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

// single-beat AXI slave, one read and one write in flight
module axi_mem_model #(
  parameter int WORDS = 256
) (
  input  logic            clk,
  input  logic            rst,
  input  bus_pkg::addr_t  araddr_i,
  input  logic            arvalid_i,
  output logic            arready_o,
  output bus_pkg::beat_t  rdata_o,
  output logic [1:0]      rresp_o,
  output logic            rvalid_o,
  output logic            rlast_o,
  input  logic            rready_i,
  input  bus_pkg::addr_t  awaddr_i,
  input  logic            awvalid_i,
  output logic            awready_o,
  input  bus_pkg::beat_t  wdata_i,
  input  bus_pkg::bstrb_t wstrb_i,
  input  logic            wvalid_i,
  output logic            wready_o,
  output logic [1:0]      bresp_o,
  output logic            bvalid_o,
  input  logic            bready_i
);

  logic [31:0]     mem [WORDS];
  logic            rd_busy;
  bus_pkg::addr_t  rd_addr;
  int              rd_wait;
  logic            aw_got;
  logic            w_got;
  bus_pkg::addr_t  wr_addr;
  bus_pkg::beat_t  wr_data;
  bus_pkg::bstrb_t wr_strb;
  int              wr_wait;

  // lower word of the 64-bit beat holding the address
  function automatic int lo_index(input bus_pkg::addr_t a);
    return int'((a >> 3) % (WORDS / 2)) * 2;
  endfunction

  assign rresp_o = bus_pkg::RESP_OKAY;
  assign bresp_o = bus_pkg::RESP_OKAY;
  assign rlast_o = rvalid_o;

  initial begin
    arready_o = 1'b0;
    rvalid_o  = 1'b0;
    rdata_o   = '0;
    awready_o = 1'b0;
    wready_o  = 1'b0;
    bvalid_o  = 1'b0;
  end

  always @(posedge clk) begin
    if (rst) begin
      arready_o <= 1'b0;
      rvalid_o  <= 1'b0;
      rd_busy   <= 1'b0;
    end else if (!rd_busy) begin
      if (arvalid_i && arready_o) begin
        rd_busy   <= 1'b1;
        rd_addr   <= araddr_i;
        rd_wait   <= $urandom % 4;  // read latency
        arready_o <= 1'b0;
      end else begin
        arready_o <= $urandom % 2;
      end
    end else if (rvalid_o && rready_i) begin
      rvalid_o <= 1'b0;
      rd_busy  <= 1'b0;
    end else if (rd_wait != 0) begin
      rd_wait <= rd_wait - 1;
    end else begin
      rvalid_o <= 1'b1;
      rdata_o  <= {mem[lo_index(rd_addr) + 1], mem[lo_index(rd_addr)]};
    end
  end

  always @(posedge clk) begin
    if (rst) begin
      awready_o <= 1'b0;
      wready_o  <= 1'b0;
      bvalid_o  <= 1'b0;
      aw_got    <= 1'b0;
      w_got     <= 1'b0;
    end else if (bvalid_o) begin
      if (bready_i) begin
        bvalid_o <= 1'b0;
        aw_got   <= 1'b0;
        w_got    <= 1'b0;
      end
    end else if (aw_got && w_got) begin
      if (wr_wait != 0) begin
        wr_wait <= wr_wait - 1;
      end else begin
        for (int j = 0; j < 8; j++) begin
          if (wr_strb[j]) mem[lo_index(wr_addr) + j / 4][8 * (j % 4) +: 8] <= wr_data[8 * j +: 8];
        end
        bvalid_o <= 1'b1;
      end
    end else begin
      if (!aw_got) begin
        if (awvalid_i && awready_o) begin
          aw_got    <= 1'b1;
          wr_addr   <= awaddr_i;
          awready_o <= 1'b0;
        end else begin
          awready_o <= $urandom % 2;
        end
      end
      if (!w_got) begin
        if (wvalid_i && wready_o) begin
          w_got    <= 1'b1;
          wr_data  <= wdata_i;
          wr_strb  <= wstrb_i;
          wready_o <= 1'b0;
        end else begin
          wready_o <= $urandom % 2;
        end
      end
      wr_wait <= $urandom % 4;  // write response latency
    end
  end

endmodule

`default_nettype wire

// File: dv/bus_sva.sv
`timescale 1ns/1ps
`default_nettype none

// two valid/ready channels, acks and one response channel
module bus_sva (
  input logic        clk,
  input logic        rst,
  input logic        vld0_i,
  input logic        rdy0_i,
  input logic [63:0] pay0_i,
  input logic        vld1_i,
  input logic        rdy1_i,
  input logic [71:0] pay1_i,
  input logic [1:0]  ack_i,
  input logic        resp_vld_i,
  input logic [1:0]  resp_i
);

  hold0_a: assert property (@(posedge clk) disable iff (rst)
    vld0_i && !rdy0_i |=> vld0_i && $stable(pay0_i))
    else $error("address valid or payload changed before ready");

  hold1_a: assert property (@(posedge clk) disable iff (rst)
    vld1_i && !rdy1_i |=> vld1_i && $stable(pay1_i))
    else $error("write data valid or payload changed before ready");

  ack_rst_a: assert property (@(posedge clk) rst |=> ack_i == 2'b00)
    else $error("ack high in the cycle after reset");

  resp_a: assert property (@(posedge clk) disable iff (rst)
    resp_vld_i |-> resp_i == bus_pkg::RESP_OKAY)
    else $error("response other than OKAY");

endmodule

bind read_arb bus_sva i_sva (
  .clk (clk), .rst (rst),
  .vld0_i (arvalid_o), .rdy0_i (arready_i), .pay0_i ({29'd0, arsize_o, araddr_o}),
  .vld1_i (1'b0), .rdy1_i (1'b0), .pay1_i (72'd0),
  .ack_i ({ifu_ack_o, ld.ack}), .resp_vld_i (rvalid_i), .resp_i (rresp_i)
);

bind store_path bus_sva i_sva (
  .clk (clk), .rst (rst),
  .vld0_i (awvalid_o), .rdy0_i (awready_i), .pay0_i ({29'd0, awsize_o, awaddr_o}),
  .vld1_i (wvalid_o), .rdy1_i (wready_i), .pay1_i ({wstrb_o, wdata_o}),
  .ack_i ({1'b0, st_ack_o}), .resp_vld_i (bvalid_i), .resp_i (bresp_i)
);

`default_nettype wire

// File: dv/bus_tb.sv
`timescale 1ns/1ps
`default_nettype none

module bus_tb;

  localparam bus_pkg::addr_t MTIME     = 32'h0200_BFF8;
  localparam int             MEM_WORDS = 256;

  typedef enum logic [2:0] {OP_FETCH, OP_LOAD, OP_STORE, OP_PAIR, OP_TIMER, OP_OVERLAP} op_t;
  typedef struct packed {
    op_t              op;
    bus_pkg::addr_t   addr;
    bus_pkg::addr_t   addr2;  // second requester or fetch beside a store
    bus_pkg::word_t   data;   // store data, or timer gap in cycles
    bus_pkg::lstrb_t  strb;
    bus_pkg::word_t   exp;
    bus_pkg::word_t   exp2;
    bus_pkg::axsize_t size;
  } entry_t;

  logic clk = 1'b0;
  logic rst;
  logic ifu_req, ifu_ack, ld_req, ld_ack, st_req, st_ack;
  bus_pkg::addr_t   ifu_addr, ld_addr, st_addr, araddr, awaddr;
  bus_pkg::addr_t   ar_addr_seen, aw_addr_seen;
  bus_pkg::word_t   ifu_rdata, ld_rdata, st_data;
  bus_pkg::lstrb_t  ld_strb, st_strb;
  bus_pkg::axsize_t arsize, awsize, ar_size_seen, aw_size_seen;
  bus_pkg::beat_t   rdata, wdata, w_data_seen;
  bus_pkg::bstrb_t  wstrb, w_strb_seen;
  logic             w_last_seen;
  logic [1:0] rresp, bresp;
  logic arvalid, arready, rvalid, rlast, rready, awvalid, awready;
  logic wlast, wvalid, wready, bvalid, bready;

  bus_pkg::word_t ref_mem [MEM_WORDS];
  entry_t         tbl [$];
  entry_t         e;
  int             cyc = 0;
  int             n_pass = 0, n_fail = 0, n_err = 0, test_err;
  int unsigned    seed, junk;
  bus_pkg::word_t got, got2;
  int             t0, t1, t2, t3;
  bus_pkg::lstrb_t  combo_strb [7] = '{4'h1, 4'h1, 4'h1, 4'h1, 4'h3, 4'h3, 4'hF};
  logic [1:0]       combo_off  [7] = '{2'd0, 2'd1, 2'd2, 2'd3, 2'd0, 2'd2, 2'd0};
  bus_pkg::axsize_t combo_size [7] = '{3'd0, 3'd0, 3'd0, 3'd0, 3'd1, 3'd1, 3'd2};

  bus_top #(.MTIME_BASE(MTIME)) i_dut (
    .clk (clk), .rst (rst),
    .ifu_req_i (ifu_req), .ifu_addr_i (ifu_addr), .ifu_ack_o (ifu_ack), .ifu_rdata_o (ifu_rdata),
    .ld_req_i (ld_req), .ld_addr_i (ld_addr), .ld_strb_i (ld_strb),
    .ld_ack_o (ld_ack), .ld_rdata_o (ld_rdata),
    .st_req_i (st_req), .st_addr_i (st_addr), .st_data_i (st_data), .st_strb_i (st_strb),
    .st_ack_o (st_ack),
    .araddr_o (araddr), .arsize_o (arsize), .arvalid_o (arvalid), .arready_i (arready),
    .rdata_i (rdata), .rresp_i (rresp), .rvalid_i (rvalid), .rlast_i (rlast), .rready_o (rready),
    .awaddr_o (awaddr), .awsize_o (awsize), .awvalid_o (awvalid), .awready_i (awready),
    .wdata_o (wdata), .wstrb_o (wstrb), .wlast_o (wlast), .wvalid_o (wvalid), .wready_i (wready),
    .bresp_i (bresp), .bvalid_i (bvalid), .bready_o (bready)
  );

  axi_mem_model #(.WORDS(MEM_WORDS)) i_mem (
    .clk (clk), .rst (rst),
    .araddr_i (araddr), .arvalid_i (arvalid), .arready_o (arready),
    .rdata_o (rdata), .rresp_o (rresp), .rvalid_o (rvalid), .rlast_o (rlast), .rready_i (rready),
    .awaddr_i (awaddr), .awvalid_i (awvalid), .awready_o (awready),
    .wdata_i (wdata), .wstrb_i (wstrb), .wvalid_i (wvalid), .wready_o (wready),
    .bresp_o (bresp), .bvalid_o (bvalid), .bready_i (bready)
  );

  always #10 clk = ~clk;
  always @(posedge clk) cyc <= cyc + 1;

  // what went out on the AXI side
  always @(posedge clk) begin
    if (arvalid && arready) begin
      ar_addr_seen <= araddr;
      ar_size_seen <= arsize;
    end
    if (awvalid && awready) begin
      aw_addr_seen <= awaddr;
      aw_size_seen <= awsize;
    end
    if (wvalid && wready) begin
      w_data_seen <= wdata;
      w_strb_seen <= wstrb;
      w_last_seen <= wlast;
    end
  end

  function automatic bus_pkg::word_t fill_word(input int unsigned idx);
    return (idx * 32'h0101_0101) ^ (idx << 20) ^ 32'hc3a5_5a3c;
  endfunction

  function automatic int ref_index(input bus_pkg::addr_t a);
    return int'((a >> 2) % MEM_WORDS);
  endfunction

  function automatic bus_pkg::addr_t rand_word_addr();
    return ($urandom % MEM_WORDS) << 2;
  endfunction

  // random word in the chosen half of a beat
  function automatic bus_pkg::addr_t rand_addr_half(input logic upper);
    return (rand_word_addr() & ~32'h4) | {29'd0, upper, 2'b00};
  endfunction

  task automatic add_entry(input op_t op, input bus_pkg::addr_t a, input bus_pkg::addr_t a2,
                           input bus_pkg::word_t d, input bus_pkg::lstrb_t s,
                           input bus_pkg::axsize_t sz);
    entry_t n;
    n = '{op, a, a2, d, s, ref_ram(a), ref_ram(a2), sz};
    if (op == OP_TIMER) begin
      n.exp  = d;  // low word advances by the gap
      n.exp2 = '0;
    end
    if (op == OP_STORE || op == OP_OVERLAP) begin
      for (int b = 0; b < 4; b++) begin
        if (s[b]) ref_mem[ref_index(a)][8 * (a[1:0] + b) +: 8] = d[8 * b +: 8];
      end
    end
    tbl.push_back(n);
  endtask

  function automatic bus_pkg::word_t ref_ram(input bus_pkg::addr_t a);
    return ref_mem[ref_index(a)];
  endfunction

  task automatic compare(input string name, input logic [63:0] val, input logic [63:0] exp);
    assert (val === exp) else begin
      $display("MISMATCH t=%0t %s: got %h, expected %h", $time, name, val, exp);
      test_err++;
    end
  endtask

  task automatic fetch_word(input bus_pkg::addr_t a, output bus_pkg::word_t d, output int t_ack);
    @(posedge clk);
    ifu_req  <= 1'b1;
    ifu_addr <= a;
    do @(negedge clk); while (!ifu_ack);
    d     = ifu_rdata;
    t_ack = cyc;
    @(posedge clk);
    ifu_req <= 1'b0;
    do @(negedge clk); while (ifu_ack);
  endtask

  task automatic load_word(input bus_pkg::addr_t a, input bus_pkg::lstrb_t s, input int start_at,
                           output bus_pkg::word_t d, output int t_req, output int t_ack);
    @(posedge clk);
    while (cyc < start_at) @(posedge clk);
    t_req = cyc;
    ld_req  <= 1'b1;
    ld_addr <= a;
    ld_strb <= s;
    do @(negedge clk); while (!ld_ack);
    d     = ld_rdata;
    t_ack = cyc;
    @(posedge clk);
    ld_req <= 1'b0;
    do @(negedge clk); while (ld_ack);
  endtask

  task automatic store_word(input bus_pkg::addr_t a, input bus_pkg::word_t d,
                            input bus_pkg::lstrb_t s);
    @(posedge clk);
    st_req  <= 1'b1;
    st_addr <= a;
    st_data <= d;
    st_strb <= s;
    do @(negedge clk); while (!st_ack);
    @(posedge clk);
    st_req <= 1'b0;
    do @(negedge clk); while (st_ack);
  endtask

  // AXI byte lanes follow the address modulo 8
  task automatic check_store_beat(input entry_t x);
    bus_pkg::word_t sh;
    sh = x.data << (8 * x.addr[1:0]);
    compare("awaddr_o", aw_addr_seen, x.addr);
    compare("wstrb_o", w_strb_seen, {4'h0, x.strb} << x.addr[2:0]);
    compare("wdata_o", w_data_seen, {sh, sh});
    compare("wlast_o", w_last_seen, 1'b1);
    compare("awsize_o", aw_size_seen, x.size);
  endtask

  initial begin
    seed = 32'h1e9130ea;
    junk = $urandom(seed);
    rst = 1'b1;
    ifu_req = 1'b0;
    ifu_addr = '0;
    ld_req = 1'b0;
    ld_addr = '0;
    ld_strb = '0;
    st_req = 1'b0;
    st_addr = '0;
    st_data = '0;
    st_strb = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      ref_mem[i] = fill_word(i);
      i_mem.mem[i] = ref_mem[i];
    end
    for (int i = 0; i < 4; i++) begin
      add_entry(OP_FETCH, rand_addr_half(i[0]), '0, '0, 4'hF, 3'd2);
    end
    for (int i = 0; i < 7; i++) begin
      add_entry(OP_LOAD, rand_addr_half(i[0]) + combo_off[i], '0, '0, combo_strb[i],
                combo_size[i]);
    end
    for (int i = 0; i < 7; i++) begin
      t0 = rand_addr_half(i[0]);
      add_entry(OP_STORE, t0 + combo_off[i], '0, $urandom, combo_strb[i], combo_size[i]);
      add_entry(OP_LOAD, t0, '0, '0, 4'hF, 3'd2);  // read back
    end
    for (int i = 0; i < 2; i++) begin
      add_entry(OP_PAIR, rand_addr_half(i[0]), rand_addr_half(~i[0]), '0, 4'hF, 3'd2);
    end
    add_entry(OP_TIMER, MTIME, MTIME + 4, 10 + $urandom % 30, 4'hF, 3'd2);
    t0 = rand_word_addr();
    add_entry(OP_OVERLAP, t0, (t0 + 32'h100) % (4 * MEM_WORDS), $urandom, 4'hF, 3'd2);
    add_entry(OP_LOAD, t0, '0, '0, 4'hF, 3'd2);
    fork
      begin
        repeat (tbl.size() * 200 + 10) @(posedge clk);
        $display("timeout: the bus did not finish the tests in time");
        $display("*** TEST FAILED ***");
        $finish;
      end
    join_none
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    foreach (tbl[n]) begin
      e = tbl[n];
      test_err = 0;
      case (e.op)
        OP_FETCH: begin
          fetch_word(e.addr, got, t1);
          compare("ifu_rdata_o", got, e.exp);
          compare("araddr_o", ar_addr_seen, e.addr);
          compare("arsize_o", ar_size_seen, e.size);
        end
        OP_LOAD: begin
          load_word(e.addr, e.strb, 0, got, t0, t1);
          compare("ld_rdata_o", got, e.exp);
          compare("araddr_o", ar_addr_seen, e.addr);
          compare("arsize_o", ar_size_seen, e.size);
        end
        OP_STORE: begin
          store_word(e.addr, e.data, e.strb);
          check_store_beat(e);
        end
        OP_PAIR: begin
          fork
            fetch_word(e.addr, got, t1);
            load_word(e.addr2, 4'hF, 0, got2, t0, t2);
          join
          compare("ifu_rdata_o", got, e.exp);
          compare("ld_rdata_o", got2, e.exp2);
          assert (t1 < t2) else begin
            $display("the load was acknowledged before the fetch of the same cycle");
            test_err++;
          end
        end
        OP_TIMER: begin
          load_word(e.addr, 4'hF, 0, got, t0, t1);
          load_word(e.addr, 4'hF, t0 + e.data, got2, t2, t3);
          compare("mtime low delta", got2 - got, e.exp);
          load_word(e.addr2, 4'hF, 0, got, t0, t1);
          compare("mtime high", got, e.exp2);
        end
        default: begin
          fork
            store_word(e.addr, e.data, e.strb);
            begin
              fetch_word(e.addr2, got, t1);
              fetch_word(e.addr2, got2, t1);
            end
          join
          compare("ifu_rdata_o", got, e.exp2);
          compare("ifu_rdata_o", got2, e.exp2);
          check_store_beat(e);
        end
      endcase
      n_err += test_err;
      if (test_err == 0) n_pass++;
      else n_fail++;
      $display("test %0d %s: %s", n, e.op.name(), (test_err == 0) ? "ok" : "errors");
    end
    $display("%0d tests, %0d passed, %0d failed, %0d check errors",
             tbl.size(), n_pass, n_fail, n_err);
    if (n_err == 0) $display("*** TEST PASSED ***");
    else $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
common/bus_pkg.sv
common/rd_if.sv
hw/load_steer.sv
hw/read_arb/read_arb.sv
hw/clint/clint_timer.sv
hw/store_path/store_path.sv
hw/bus_top.sv
dv/axi_mem_model.sv
dv/bus_sva.sv
dv/bus_tb.sv
